// File: branch_unit.sv
// resolves branches and jumps in decode and tells fetch when to redirect or wait
`timescale 1ns/1ns

module branch_unit import rv_isa_pkg::*, id_ctrl_pkg::*; (
  input  logic                 i_valid,
  input  logic [BR_FUNC_W-1:0] i_br_func,
  input  logic [XLEN-1:0]      i_pc,
  input  logic [XLEN-1:0]      i_rs1_data,
  input  logic [XLEN-1:0]      i_rs2_data,
  input  logic [XLEN-1:0]      i_imm,
  input  logic [XLEN-1:0]      i_fs_pc,
  input  logic                 i_hazard,
  output logic                 o_br_sel,
  output logic [XLEN-1:0]      o_br_target,
  output logic                 o_br_stall
);

  logic            equal, signed_lt, unsigned_lt;
  logic            taken;
  logic [XLEN-1:0] jalr_sum;

  assign equal       = i_rs1_data == i_rs2_data;
  assign signed_lt   = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign unsigned_lt = i_rs1_data < i_rs2_data;

  always_comb begin
    case (i_br_func)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_EQ:           taken = equal;
      BR_NE:           taken = !equal;
      BR_LT:           taken = signed_lt;
      BR_GE:           taken = !signed_lt;
      BR_LTU:          taken = unsigned_lt;
      BR_GEU:          taken = !unsigned_lt;
      default:         taken = 1'b0;
    endcase
  end

  assign jalr_sum    = i_rs1_data + i_imm;
  assign o_br_target = (i_br_func == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;
  assign o_br_sel    = i_valid && taken;

  // fetch already on the target needs no redirect
  assign o_br_stall  = o_br_sel && (i_hazard || o_br_target != i_fs_pc);

  // pc-relative targets stay even only if fetch hands over even pcs
  always_comb begin
    if (o_br_sel) begin
      a_target_even : assert (!o_br_target[0]);
    end
  end

endmodule

// File: gpr_file.sv
// general register file, two async reads for decode and one write port from write-back
`timescale 1ns/1ns

module gpr_file import rv_isa_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [GPR_ADDR_W-1:0] i_raddr1,
  input  logic [GPR_ADDR_W-1:0] i_raddr2,
  output logic [XLEN-1:0]       o_rdata1,
  output logic [XLEN-1:0]       o_rdata2,
  input  logic                  i_wen,
  input  logic [GPR_ADDR_W-1:0] i_waddr,
  input  logic [XLEN-1:0]       i_wdata
);

  logic [XLEN-1:0] regs [1:GPR_NUM-1]; // x0 has no storage

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int k = 1; k < GPR_NUM; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // same-cycle write is not bypassed, the interlock covers it
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // registers clear on reset, so a known address reads a known value
  a_no_x_read : assert property (
    @(posedge i_clk) disable iff (i_rst)
    !$isunknown({i_raddr1, i_raddr2}) |-> !$isunknown({o_rdata1, o_rdata2})
  );

endmodule

// File: hazard_unit.sv
// read-after-write interlock against rd of execute, memory and write-back
`timescale 1ns/1ns

module hazard_unit import rv_isa_pkg::*; (
  input  logic [GPR_ADDR_W-1:0] i_rs1,
  input  logic [GPR_ADDR_W-1:0] i_rs2,
  input  logic [GPR_ADDR_W-1:0] i_es_rd,
  input  logic [GPR_ADDR_W-1:0] i_ms_rd,
  input  logic [GPR_ADDR_W-1:0] i_ws_rd,
  output logic                  o_hazard
);

  logic es_hit, ms_hit, ws_hit;

  // x0 never carries a pending write
  function automatic logic rd_match(
    input logic [GPR_ADDR_W-1:0] rd,
    input logic [GPR_ADDR_W-1:0] rs1,
    input logic [GPR_ADDR_W-1:0] rs2
  );
    return (rd != '0) && (rd == rs1 || rd == rs2);
  endfunction

  assign es_hit = rd_match(i_es_rd, i_rs1, i_rs2);
  assign ms_hit = rd_match(i_ms_rd, i_rs1, i_rs2);
  assign ws_hit = rd_match(i_ws_rd, i_rs1, i_rs2); // also the write-this-cycle case

  assign o_hazard = es_hit || ms_hit || ws_hit;

endmodule

// File: id_ctrl_pkg.sv
// control field encodings that decode hands to the branch unit and the execute stage
package id_ctrl_pkg;

  localparam int ALU_OP_W = 5;

  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 5'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 5'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 5'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 5'd3;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 5'd4;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 5'd5;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 5'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 5'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 5'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 5'd9;
  localparam logic [ALU_OP_W-1:0] ALU_LUI  = 5'd10; // passes operand 2

  // operand selects
  localparam logic       SRC1_RS1  = 1'b0;
  localparam logic       SRC1_PC   = 1'b1;
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2; // link address for jumps

  // memory op is funct3 as is
  localparam int MEM_OP_W = 3;

  // nine branch functions, so one bit wider than funct3
  localparam int BR_FUNC_W = 4;

  localparam logic [BR_FUNC_W-1:0] BR_NONE = 4'd0;
  localparam logic [BR_FUNC_W-1:0] BR_JAL  = 4'd1;
  localparam logic [BR_FUNC_W-1:0] BR_JALR = 4'd2;
  localparam logic [BR_FUNC_W-1:0] BR_EQ   = 4'd3;
  localparam logic [BR_FUNC_W-1:0] BR_NE   = 4'd4;
  localparam logic [BR_FUNC_W-1:0] BR_LT   = 4'd5;
  localparam logic [BR_FUNC_W-1:0] BR_GE   = 4'd6;
  localparam logic [BR_FUNC_W-1:0] BR_LTU  = 4'd7;
  localparam logic [BR_FUNC_W-1:0] BR_GEU  = 4'd8;

endpackage

// File: id_decoder.sv
// combinational RV64I subset decoder, registered instruction in, control fields out
`timescale 1ns/1ns

module id_decoder import rv_isa_pkg::*, id_ctrl_pkg::*; (
  input  inst_u                 i_inst,
  output logic [GPR_ADDR_W-1:0] o_rs1,
  output logic [GPR_ADDR_W-1:0] o_rs2,
  output logic [GPR_ADDR_W-1:0] o_rd,
  output logic [XLEN-1:0]       o_imm,
  output logic [ALU_OP_W-1:0]   o_alu_op,
  output logic                  o_alu_src1_sel,
  output logic [1:0]            o_alu_src2_sel,
  output logic                  o_word_cut,
  output logic                  o_gpr_wen,
  output logic                  o_mem_ren,
  output logic                  o_mem_wen,
  output logic [MEM_OP_W-1:0]   o_mem_op,
  output logic [BR_FUNC_W-1:0]  o_br_func,
  output logic                  o_invalid
);

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  // shared by op and op-imm
  function automatic logic [ALU_OP_W-1:0] alu_from_f3(
    input logic [2:0] f3,
    input logic       sub_sel,
    input logic       sra_sel
  );
    case (f3)
      F3_ADD:  return sub_sel ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return sra_sel ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign o_rs1 = i_inst.r.rs1;
  assign o_rs2 = i_inst.r.rs2; // compared for every format
  assign o_rd  = i_inst.r.rd;
  assign o_word_cut = 1'b0; // no W-suffix ops in this subset

  assign imm_i = {{52{i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_s = {{52{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
  assign imm_b = {{51{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                  i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
  assign imm_u = {{32{i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'b0};
  assign imm_j = {{43{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                  i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

  always_comb begin
    o_imm          = imm_i;
    o_alu_op       = ALU_ADD;
    o_alu_src1_sel = SRC1_RS1;
    o_alu_src2_sel = SRC2_IMM;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_mem_op       = i_inst.r.funct3;
    o_br_func      = BR_NONE;
    o_invalid      = 1'b0;
    case (i_inst.r.opcode)
      OPC_LUI: begin
        o_imm     = imm_u;
        o_alu_op  = ALU_LUI;
        o_gpr_wen = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm          = imm_u;
        o_alu_src1_sel = SRC1_PC;
        o_gpr_wen      = 1'b1;
      end
      OPC_OP_IMM: begin
        o_alu_op  = alu_from_f3(i_inst.i.funct3, 1'b0, i_inst.i.imm[10]);
        o_gpr_wen = 1'b1;
      end
      OPC_OP: begin
        o_alu_op       = alu_from_f3(i_inst.r.funct3, i_inst.r.funct7 == F7_SUB,
                                     i_inst.r.funct7[5]);
        o_alu_src2_sel = SRC2_RS2;
        o_gpr_wen      = 1'b1;
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        case (i_inst.b.funct3)
          F3_BEQ:  o_br_func = BR_EQ;
          F3_BNE:  o_br_func = BR_NE;
          F3_BLT:  o_br_func = BR_LT;
          F3_BGE:  o_br_func = BR_GE;
          F3_BLTU: o_br_func = BR_LTU;
          F3_BGEU: o_br_func = BR_GEU;
          default: o_invalid = 1'b1; // 010 and 011 unused
        endcase
      end
      OPC_JAL, OPC_JALR: begin
        o_imm          = (i_inst.r.opcode == OPC_JAL) ? imm_j : imm_i;
        o_alu_src1_sel = SRC1_PC;
        o_alu_src2_sel = SRC2_FOUR; // rd gets pc + 4
        o_gpr_wen      = 1'b1;
        o_br_func      = (i_inst.r.opcode == OPC_JAL) ? BR_JAL : BR_JALR;
      end
      OPC_LOAD: begin
        o_mem_ren = 1'b1;
        o_gpr_wen = 1'b1;
      end
      OPC_STORE: begin
        o_imm     = imm_s;
        o_mem_wen = 1'b1;
      end
      default: o_invalid = 1'b1;
    endcase
    if (o_invalid) begin
      o_gpr_wen = 1'b0;
      o_mem_wen = 1'b0;
      o_mem_ren = 1'b0;
      o_br_func = BR_NONE;
    end
  end

endmodule

// File: id_pipe_reg.sv
// decode stage valid/allowin register, takes the fetched instruction and pc on acceptance
`timescale 1ns/1ns

module id_pipe_reg import rv_isa_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_fs_valid,
  input  logic [INST_W-1:0] i_fs_inst,
  input  logic [XLEN-1:0]   i_fs_pc,
  input  logic              i_es_allowin,
  input  logic              i_hazard,
  input  logic              i_br_stall,
  output logic              o_ds_allowin,
  output logic              o_ds_to_es_valid,
  output logic              o_valid,
  output inst_u             o_inst,
  output logic [XLEN-1:0]   o_pc
);

  logic ds_valid;
  logic ready_go;

  assign ready_go         = !i_hazard && !i_br_stall;
  assign o_ds_allowin     = !ds_valid || (ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ready_go;
  assign o_valid          = ds_valid;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid; // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

  // fetch keeps its offer steady until the stage takes it
  a_fetch_holds_offer : assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_fs_valid && !o_ds_allowin |=> i_fs_valid && $stable(i_fs_inst) && $stable(i_fs_pc)
  );

endmodule

// File: id_stage.sv
// decode stage top, connects pipeline register, decoder, registers, interlock and branch unit
`timescale 1ns/1ns

module id_stage import rv_isa_pkg::*, id_ctrl_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // from fetch
  input  logic                  i_fs_valid,
  input  logic [INST_W-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]       i_fs_pc,
  output logic                  o_ds_allowin,
  // execute handshake
  input  logic                  i_es_allowin,
  output logic                  o_ds_to_es_valid,
  // destinations in flight
  input  logic [GPR_ADDR_W-1:0] i_es_rd,
  input  logic [GPR_ADDR_W-1:0] i_ms_rd,
  input  logic [GPR_ADDR_W-1:0] i_ws_rd,
  // write-back port
  input  logic                  i_wb_wen,
  input  logic [GPR_ADDR_W-1:0] i_wb_waddr,
  input  logic [XLEN-1:0]       i_wb_wdata,
  // to execute
  output logic [XLEN-1:0]       o_rs1_data,
  output logic [XLEN-1:0]       o_rs2_data,
  output logic [XLEN-1:0]       o_imm,
  output logic [XLEN-1:0]       o_pc,
  output logic [ALU_OP_W-1:0]   o_alu_op,
  output logic                  o_alu_src1_sel,
  output logic [1:0]            o_alu_src2_sel,
  output logic                  o_word_cut,
  output logic [GPR_ADDR_W-1:0] o_rd,
  output logic                  o_gpr_wen,
  output logic                  o_mem_ren,
  output logic                  o_mem_wen,
  output logic [MEM_OP_W-1:0]   o_mem_op,
  output logic                  o_invalid,
  // to fetch
  output logic                  o_br_sel,
  output logic [XLEN-1:0]       o_br_target,
  output logic                  o_br_stall
);

  logic                  ds_valid;
  inst_u                 ds_inst;
  logic [GPR_ADDR_W-1:0] rs1, rs2;
  logic [BR_FUNC_W-1:0]  br_func;
  logic                  ds_hazard;

  id_pipe_reg u_pipe_reg (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_valid       (i_fs_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_hazard         (ds_hazard),
    .i_br_stall       (o_br_stall),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_valid          (ds_valid),
    .o_inst           (ds_inst),
    .o_pc             (o_pc)
  );

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_alu_src1_sel (o_alu_src1_sel),
    .o_alu_src2_sel (o_alu_src2_sel),
    .o_word_cut     (o_word_cut),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_br_func      (br_func),
    .o_invalid      (o_invalid)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_waddr),
    .i_wdata  (i_wb_wdata)
  );

  hazard_unit u_hazard (
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .i_es_rd  (i_es_rd),
    .i_ms_rd  (i_ms_rd),
    .i_ws_rd  (i_ws_rd),
    .o_hazard (ds_hazard)
  );

  branch_unit u_branch (
    .i_valid     (ds_valid),
    .i_br_func   (br_func),
    .i_pc        (o_pc),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_imm       (o_imm),
    .i_fs_pc     (i_fs_pc),
    .i_hazard    (ds_hazard),
    .o_br_sel    (o_br_sel),
    .o_br_target (o_br_target),
    .o_br_stall  (o_br_stall)
  );

endmodule

// File: id_trace.txt
# W addr data | I/H inst pc fs_pc es_rd ms_rd ws_rd es_allowin, then expected:
# to_es_valid allowin rs1 rs2 imm alu_op src2 rd gwen mren mwen mop inv br_sel target stall
W 1 10
W 2 3
W 3 ffffffffffffffff
W 4 1001
W 5 3
I ffe08313 100 104 0 0 0 1 1 1 10 0 fffffffffffffffe 0 1 6 1 0 0 0 0 0 fe 0
I 402083b3 104 108 0 0 0 1 1 1 10 3 402 1 0 7 1 0 0 0 0 0 506 0
I 80000437 108 10c 0 0 0 1 1 1 0 0 ffffffff80000000 a 1 8 1 0 0 0 0 0 ffffffff80000108 0
I 002084b3 10c 110 2 0 0 1 0 0 10 3 2 0 0 9 1 0 0 0 0 0 10e 0
H 0 0 110 0 1 0 1 0 0 10 3 2 0 0 9 1 0 0 0 0 0 10e 0
H 0 0 110 0 0 2 1 0 0 10 3 2 0 0 9 1 0 0 0 0 0 10e 0
H 0 0 110 0 0 0 1 1 1 10 3 2 0 0 9 1 0 0 0 0 0 10e 0
I 0020f533 110 114 0 0 0 0 1 0 10 3 2 4 0 a 1 0 0 7 0 0 112 0
H 0 0 114 0 0 0 0 1 0 10 3 2 4 0 a 1 0 0 7 0 0 112 0
H 0 0 114 0 0 0 1 1 1 10 3 2 4 0 a 1 0 0 7 0 0 112 0
I 00510863 200 210 0 0 0 1 1 1 3 3 10 0 1 10 0 0 0 0 0 1 210 0
I 00208863 204 208 0 0 0 1 1 1 10 3 10 0 1 10 0 0 0 0 0 0 214 0
I 0011c463 300 304 0 0 0 1 0 0 ffffffffffffffff 10 8 0 1 8 0 0 0 4 0 1 308 1
H 0 0 308 0 0 0 1 1 1 ffffffffffffffff 10 8 0 1 8 0 0 0 4 0 1 308 0
I 0011e463 308 30c 0 0 0 1 1 1 ffffffffffffffff 10 8 0 1 8 0 0 0 6 0 0 310 0
I 020000ef 400 420 0 0 0 1 1 1 0 0 20 0 2 1 1 0 0 0 0 1 420 0
I 00220067 500 504 0 0 0 1 0 0 1001 3 2 0 2 0 1 0 0 0 0 1 1002 1
H 0 0 1002 0 0 0 1 1 1 1001 3 2 0 2 0 1 0 0 0 0 1 1002 0
I 0080b583 600 604 0 0 0 1 1 1 10 0 8 0 1 b 1 1 0 3 0 0 608 0
I 0020b823 604 608 0 0 0 1 1 1 10 3 10 0 1 10 0 0 1 3 0 0 614 0
I 0000007f 700 704 0 0 0 1 1 1 0 0 0 0 1 0 0 0 0 0 1 0 700 0

// File: run_sim.sh
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_id_stage -o sim_id_stage
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_id_stage > sim.log 2>&1
status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

exit 0

// File: rv_isa_pkg.sv
// RV64I widths, encodings and instruction layouts, imported by the decode and branch logic
package rv_isa_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int GPR_ADDR_W = 5;
  localparam int GPR_NUM    = 32;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // integer op funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // srl or sra by bit 30
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [GPR_ADDR_W-1:0] rs2;
    logic [GPR_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [GPR_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [GPR_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [GPR_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0]            imm_11_5;
    logic [GPR_ADDR_W-1:0] rs2;
    logic [GPR_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_4_0;
    logic [6:0]            opcode;
  } inst_s_t;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [GPR_ADDR_W-1:0] rs2;
    logic [GPR_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    logic [6:0]            opcode;
  } inst_b_t;

  typedef struct packed {
    logic [19:0]           imm_31_12;
    logic [GPR_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } inst_u_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [GPR_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } inst_j_t;

  // one word, six layouts
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_b_t b;
    inst_u_t u;
    inst_j_t j;
  } inst_u;

endpackage

// File: sources.f
rv_isa_pkg.sv
id_ctrl_pkg.sv
id_pipe_reg.sv
id_decoder.sv
gpr_file.sv
hazard_unit.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

// File: tb_id_stage.sv
// self-checking testbench for the decode stage, replays id_trace.txt step by step
`timescale 1ns/1ns

module tb_id_stage;
  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_fs_valid;
  logic [INST_W-1:0]     i_fs_inst;
  logic [XLEN-1:0]       i_fs_pc;
  logic                  o_ds_allowin;
  logic                  i_es_allowin;
  logic                  o_ds_to_es_valid;
  logic [GPR_ADDR_W-1:0] i_es_rd, i_ms_rd, i_ws_rd;
  logic                  i_wb_wen;
  logic [GPR_ADDR_W-1:0] i_wb_waddr;
  logic [XLEN-1:0]       i_wb_wdata;
  logic [XLEN-1:0]       o_rs1_data, o_rs2_data, o_imm, o_pc;
  logic [ALU_OP_W-1:0]   o_alu_op;
  logic                  o_alu_src1_sel;
  logic [1:0]            o_alu_src2_sel;
  logic                  o_word_cut;
  logic [GPR_ADDR_W-1:0] o_rd;
  logic                  o_gpr_wen, o_mem_ren, o_mem_wen;
  logic [MEM_OP_W-1:0]   o_mem_op;
  logic                  o_invalid;
  logic                  o_br_sel;
  logic [XLEN-1:0]       o_br_target;
  logic                  o_br_stall;

  id_stage UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic report_bad_line(input string text);
    $display("trace line could not be parsed: %s", text);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // operand 1 is the pc for auipc and the jumps
  function automatic logic src1_for_opcode(input logic [6:0] opc);
    return (opc == OPC_AUIPC || opc == OPC_JAL || opc == OPC_JALR) ? SRC1_PC : SRC1_RS1;
  endfunction

  // drive point is 1 ns after the edge, checks happen mid-cycle
  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic wait_allowin();
    int n;
    n = 0;
    #4;
    while (!o_ds_allowin) begin
      if (n == 50) begin
        $display("timeout: stage never accepted the instruction within 50 cycles");
        $display("FAIL: see errors above");
        $fatal(1);
      end
      n++;
      @(posedge i_clk);
      #5;
    end
  endtask

  task automatic check_outputs(input logic [63:0] e [0:15], input logic [63:0] exp_pc,
                               input logic exp_src1);
    check_eq(64'(o_ds_to_es_valid), e[0],  "o_ds_to_es_valid");
    check_eq(64'(o_ds_allowin),     e[1],  "o_ds_allowin");
    check_eq(o_rs1_data,            e[2],  "o_rs1_data");
    check_eq(o_rs2_data,            e[3],  "o_rs2_data");
    check_eq(o_imm,                 e[4],  "o_imm");
    check_eq(64'(o_alu_op),         e[5],  "o_alu_op");
    check_eq(64'(o_alu_src2_sel),   e[6],  "o_alu_src2_sel");
    check_eq(64'(o_rd),             e[7],  "o_rd");
    check_eq(64'(o_gpr_wen),        e[8],  "o_gpr_wen");
    check_eq(64'(o_mem_ren),        e[9],  "o_mem_ren");
    check_eq(64'(o_mem_wen),        e[10], "o_mem_wen");
    check_eq(64'(o_mem_op),         e[11], "o_mem_op");
    check_eq(64'(o_invalid),        e[12], "o_invalid");
    check_eq(64'(o_br_sel),         e[13], "o_br_sel");
    check_eq(o_br_target,           e[14], "o_br_target");
    check_eq(64'(o_br_stall),       e[15], "o_br_stall");
    check_eq(o_pc,                  exp_pc, "o_pc");
    check_eq(64'(o_alu_src1_sel),   64'(exp_src1), "o_alu_src1_sel");
    check_eq(64'(o_word_cut),       64'd0, "o_word_cut"); // no W ops in the subset
  endtask

  initial begin
    int            fd;
    int            cnt;
    int            steps;
    string         line;
    logic [7:0]    cmd;
    logic [63:0]   a, b, fs_pc, es_rd, ms_rd, ws_rd, allow;
    logic [63:0]   e [0:15];
    logic [63:0]   cur_pc;
    logic          cur_src1;

    i_rst        = 1'b1;
    i_fs_valid   = 1'b0;
    i_fs_inst    = '0;
    i_fs_pc      = '0;
    i_es_allowin = 1'b1;
    i_es_rd      = '0;
    i_ms_rd      = '0;
    i_ws_rd      = '0;
    i_wb_wen     = 1'b0;
    i_wb_waddr   = '0;
    i_wb_wdata   = '0;
    steps        = 0;
    cur_pc       = '0;
    cur_src1     = SRC1_RS1;

    repeat (3) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    #4;
    check_eq(64'(o_ds_to_es_valid), 64'd0, "o_ds_to_es_valid after reset");
    check_eq(64'(o_br_sel), 64'd0, "o_br_sel after reset");
    check_eq(64'(o_br_stall), 64'd0, "o_br_stall after reset");
    check_eq(64'(o_ds_allowin), 64'd1, "o_ds_allowin after reset");
    next_cycle();

    fd = $fopen("id_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open id_trace.txt");
      $display("FAIL: see errors above");
      $fatal(1);
    end

    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      cmd = 8'h0;
      if (cnt > 0) cnt = $sscanf(line, "%c", cmd);
      if (cmd == "W") begin
        cnt = $sscanf(line, "%c %h %h", cmd, a, b);
        if (cnt != 3) report_bad_line(line);
        i_wb_wen   = 1'b1;
        i_wb_waddr = a[4:0];
        i_wb_wdata = b;
        next_cycle();
        i_wb_wen   = 1'b0;
        steps++;
      end else if (cmd == "I" || cmd == "H") begin
        cnt = $sscanf(line,
          "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          cmd, a, b, fs_pc, es_rd, ms_rd, ws_rd, allow, e[0], e[1], e[2], e[3],
          e[4], e[5], e[6], e[7], e[8], e[9], e[10], e[11], e[12], e[13], e[14], e[15]);
        if (cnt != 24) report_bad_line(line);
        if (cmd == "I") begin
          i_fs_valid = 1'b1;
          i_fs_inst  = a[31:0];
          i_fs_pc    = b;
          cur_pc     = b;
          cur_src1   = src1_for_opcode(a[6:0]);
          wait_allowin();
          next_cycle(); // accepted on this edge
          i_fs_valid = 1'b0;
        end
        i_fs_pc      = fs_pc;
        i_es_rd      = es_rd[4:0];
        i_ms_rd      = ms_rd[4:0];
        i_ws_rd      = ws_rd[4:0];
        i_es_allowin = allow[0];
        #4;
        check_outputs(e, cur_pc, cur_src1);
        next_cycle();
        steps++;
      end
    end
    $fclose(fd);

    if (steps == 0) begin
      $display("id_trace.txt held no steps to run");
      $display("FAIL: see errors above");
      $fatal(1);
    end else begin
      $display("%0d trace steps done", steps);
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule
